//--- Bender.yml
package:
  name: fetch_icache

sources:
  - files:
      - hw/fetch_pkg.sv
      - hw/mem_pkg.sv
      - hw/refill_counter.sv
      - hw/icache_array.sv
      - hw/icache_ctrl.sv
      - hw/icache.sv
      - hw/if1_stage.sv
      - hw/fetch_top.sv
  - target: test
    files:
      - tests/fetch_chk.sv
      - tests/tb_fetch.sv

//--- filelist.f
hw/fetch_pkg.sv
hw/mem_pkg.sv
hw/refill_counter.sv
hw/icache_array.sv
hw/icache_ctrl.sv
hw/icache.sv
hw/if1_stage.sv
hw/fetch_top.sv
tests/fetch_chk.sv
tests/tb_fetch.sv

//--- hw/fetch_pkg.sv
package fetch_pkg;

    // Instructions handed downstream per fetch
    localparam int IF_WIDTH = 2;

    // Every fetch address is aligned to one fetch block
    localparam int BLK_BYTES = IF_WIDTH * 4;

    // Byte address as seen by the front end
    typedef logic [31:0] addr_t;

    // One raw instruction word
    typedef logic [31:0] inst_t;

    // Fetch block, element 0 is the word at the lower address
    typedef inst_t [IF_WIDTH-1:0] fetch_blk_t;

endpackage

//--- hw/fetch_top.sv
`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*, mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       flush,

    input  logic       prv_valid,
    output logic       prv_ready,

    output logic       nxt_valid,
    input  logic       nxt_ready,

    input  addr_t      pc_next,

    output addr_t      pc,
    output fetch_blk_t insts,

    output mem_req_t   mem_req,
    input  mem_rsp_t   mem_rsp
);

    if1_stage if1_i (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .prv_valid (prv_valid),
        .prv_ready (prv_ready),
        .nxt_valid (nxt_valid),
        .nxt_ready (nxt_ready),
        .pc_next   (pc_next),
        .pc        (pc),
        .insts     (insts),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

endmodule

//--- hw/icache.sv
`timescale 1ns/1ps

module icache
    import fetch_pkg::*, mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // Upstream port
    input  addr_t      ufp_addr,
    input  logic       ufp_read,
    output fetch_blk_t ufp_rdata,
    output logic       ufp_resp,
    input  logic       kill,

    // Memory port
    output mem_req_t   mem_req,
    input  mem_rsp_t   mem_rsp
);

    logic      lookup_en;
    addr_t     lookup_addr;
    logic      hit;
    logic      miss_start;
    beat_cnt_t beat_idx;
    logic      last;
    logic      fill_done;
    addr_t     fill_addr;

    // Line being refilled, taken from the outgoing request
    always_ff @(posedge clk) begin
        if (mem_req.read) begin
            fill_addr <= mem_req.addr;
        end
    end

    assign fill_done = mem_rsp.valid && last;

    icache_ctrl ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .ufp_read    (ufp_read),
        .ufp_addr    (ufp_addr),
        .kill        (kill),
        .hit         (hit),
        .last        (last),
        .beat_valid  (mem_rsp.valid),
        .lookup_en   (lookup_en),
        .lookup_addr (lookup_addr),
        .miss_start  (miss_start),
        .req         (mem_req),
        .ufp_resp    (ufp_resp)
    );

    refill_counter counter_i (
        .clk   (clk),
        .rst   (rst),
        .start (miss_start),
        .beat  (mem_rsp.valid),
        .idx   (beat_idx),
        .last  (last)
    );

    icache_array array_i (
        .clk       (clk),
        .rst       (rst),
        .rd_en     (lookup_en),
        .rd_addr   (lookup_addr),
        .hit       (hit),
        .rd_blk    (ufp_rdata),
        .wr_en     (mem_rsp.valid),
        .wr_addr   (fill_addr),
        .beat_data (mem_rsp.data),
        .beat_idx  (beat_idx),
        .fill_done (fill_done)
    );

endmodule

//--- hw/icache_array.sv
`timescale 1ns/1ps

module icache_array
    import fetch_pkg::*, mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // Lookup side
    input  logic       rd_en,
    input  addr_t      rd_addr,
    output logic       hit,
    output fetch_blk_t rd_blk,

    // Refill side
    input  logic       wr_en,
    input  addr_t      wr_addr,
    input  beat_t      beat_data,
    input  beat_cnt_t  beat_idx,
    input  logic       fill_done
);

    logic [SETS-1:0]       valid_q;
    tag_t                  tag_q  [SETS];
    beat_t [BEATS-1:0]     data_q [SETS];

    // Line assembly buffer for beats in flight
    beat_t [BEATS-1:0]     fill_buf;
    beat_t [BEATS-1:0]     fill_line;

    index_t                rd_idx;
    tag_t                  rd_tag;
    beat_cnt_t             rd_beat;
    index_t                wr_idx;

    assign rd_idx  = rd_addr[OFFSET_BITS +: INDEX_BITS];
    assign rd_tag  = rd_addr[OFFSET_BITS + INDEX_BITS +: TAG_BITS];
    assign rd_beat = rd_addr[BEAT_OFS +: $bits(beat_cnt_t)];
    assign wr_idx  = wr_addr[OFFSET_BITS +: INDEX_BITS];

    // Final beat goes straight into the line, bypassing the buffer
    always_comb begin
        fill_line           = fill_buf;
        fill_line[beat_idx] = beat_data;
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            fill_buf[beat_idx] <= beat_data;
        end
        if (fill_done) begin
            data_q[wr_idx] <= fill_line;
            tag_q[wr_idx]  <= wr_addr[OFFSET_BITS + INDEX_BITS +: TAG_BITS];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill_done) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Registered read, result appears the cycle after rd_en
    always_ff @(posedge clk) begin
        if (rst) begin
            hit <= 1'b0;
        end else if (rd_en) begin
            hit <= valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_blk <= data_q[rd_idx][rd_beat];
        end
    end

endmodule

//--- hw/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl
    import fetch_pkg::*, mem_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    input  logic     ufp_read,
    input  addr_t    ufp_addr,
    input  logic     kill,

    input  logic     hit,
    input  logic     last,
    input  logic     beat_valid,

    output logic     lookup_en,
    output addr_t    lookup_addr,
    output logic     miss_start,
    output mem_req_t req,
    output logic     ufp_resp
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        REQUEST,
        REFILL,
        REPLAY
    } state_e;

    state_e state_q, state_d;

    // Live request and its kill flag
    addr_t  addr_q, addr_d;
    logic   killed_q, killed_d;

    // One-entry slot for a read that lands while a refill is busy
    logic   def_v_q, def_v_d;
    addr_t  def_addr_q, def_addr_d;

    logic   busy;
    logic   start_en;
    addr_t  start_addr;

    assign busy = (state_q == REQUEST) || (state_q == REFILL) ||
                  (state_q == LOOKUP && !hit);

    always_comb begin
        state_d    = state_q;
        addr_d     = addr_q;
        killed_d   = killed_q;
        def_v_d    = def_v_q;
        def_addr_d = def_addr_q;
        start_en   = 1'b0;
        start_addr = ufp_addr;
        ufp_resp   = 1'b0;

        // A kill drops the live response and anything parked behind it
        if (busy) begin
            if (kill) begin
                killed_d = 1'b1;
                def_v_d  = 1'b0;
            end
            if (ufp_read) begin
                def_v_d    = 1'b1;
                def_addr_d = ufp_addr;
            end
        end

        case (state_q)
            IDLE: begin
                start_en = ufp_read;
            end
            LOOKUP: begin
                if (hit) begin
                    ufp_resp = !kill;
                    if (ufp_read) begin
                        start_en = 1'b1;
                    end else if (def_v_q) begin
                        start_en   = 1'b1;
                        start_addr = def_addr_q;
                        def_v_d    = 1'b0;
                    end else begin
                        state_d = IDLE;
                    end
                end else begin
                    state_d = REQUEST;
                end
            end
            REQUEST: begin
                state_d = REFILL;
            end
            REFILL: begin
                if (beat_valid && last) begin
                    state_d = REPLAY;
                end
            end
            REPLAY: begin
                if (kill) begin
                    // Only a read arriving with the kill survives
                    def_v_d  = 1'b0;
                    start_en = ufp_read;
                    state_d  = IDLE;
                end else if (!killed_q) begin
                    start_en   = 1'b1;
                    start_addr = addr_q;
                    if (ufp_read) begin
                        def_v_d    = 1'b1;
                        def_addr_d = ufp_addr;
                    end
                end else if (def_v_q) begin
                    start_en   = 1'b1;
                    start_addr = def_addr_q;
                    def_v_d    = ufp_read;
                    def_addr_d = ufp_addr;
                end else begin
                    start_en = ufp_read;
                    state_d  = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase

        if (start_en) begin
            state_d  = LOOKUP;
            addr_d   = start_addr;
            killed_d = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= IDLE;
            killed_q <= 1'b0;
            def_v_q  <= 1'b0;
        end else begin
            state_q  <= state_d;
            killed_q <= killed_d;
            def_v_q  <= def_v_d;
        end
    end

    always_ff @(posedge clk) begin
        addr_q     <= addr_d;
        def_addr_q <= def_addr_d;
    end

    assign lookup_en   = start_en;
    assign lookup_addr = start_addr;

    // Miss request goes out from REQUEST, line aligned
    assign miss_start = (state_q == REQUEST);
    assign req.read   = (state_q == REQUEST);
    assign req.addr   = {addr_q[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

endmodule

//--- hw/if1_stage.sv
`timescale 1ns/1ps

module if1_stage
    import fetch_pkg::*, mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       flush,

    // Upstream handshake
    input  logic       prv_valid,
    output logic       prv_ready,

    // Downstream handshake
    output logic       nxt_valid,
    input  logic       nxt_ready,

    input  addr_t      pc_next,

    output addr_t      pc,
    output fetch_blk_t insts,

    // Line refill port
    output mem_req_t   mem_req,
    input  mem_rsp_t   mem_rsp
);

    logic       fetch_valid;
    logic       fetch_pending;
    logic       accept;
    logic       icache_resp;
    fetch_blk_t icache_rdata;
    fetch_blk_t hold_blk;

    // Stage frees up when empty, when draining this cycle, or on flush
    assign prv_ready = !fetch_valid || (nxt_valid && nxt_ready) || flush;
    assign accept    = prv_valid && prv_ready;

    always_ff @(posedge clk) begin
        if (accept) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_valid <= 1'b0;
        end else if (prv_ready) begin
            fetch_valid <= prv_valid;
        end
    end

    // Waiting on the cache for the held PC
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_pending <= 1'b0;
        end else if (accept) begin
            fetch_pending <= 1'b1;
        end else if (icache_resp || flush) begin
            fetch_pending <= 1'b0;
        end
    end

    icache icache_i (
        .clk       (clk),
        .rst       (rst),
        .ufp_addr  (pc_next),
        .ufp_read  (accept),
        .ufp_rdata (icache_rdata),
        .ufp_resp  (icache_resp),
        .kill      (flush),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

    // Keeps the block stable while downstream stalls
    always_ff @(posedge clk) begin
        if (icache_resp) begin
            hold_blk <= icache_rdata;
        end
    end

    assign insts = icache_resp ? icache_rdata : hold_blk;

    // Nothing leaves while the cache is still working or on a flush
    assign nxt_valid = fetch_valid && !(fetch_pending && !icache_resp) && !flush;

endmodule

//--- hw/mem_pkg.sv
package mem_pkg;

    localparam int ADDR_BITS  = 32;
    localparam int LINE_WORDS = 8;
    localparam int SETS       = 16;
    localparam int BEAT_BITS  = 64;
    localparam int BEATS      = LINE_WORDS * 32 / BEAT_BITS;

    // Address split: | tag | index | beat | byte |
    localparam int OFFSET_BITS = $clog2(LINE_WORDS * 4);
    localparam int INDEX_BITS  = $clog2(SETS);
    localparam int TAG_BITS    = ADDR_BITS - INDEX_BITS - OFFSET_BITS;
    localparam int BEAT_OFS    = $clog2(BEAT_BITS / 8);

    typedef logic [TAG_BITS-1:0]       tag_t;
    typedef logic [INDEX_BITS-1:0]     index_t;
    typedef logic [BEAT_BITS-1:0]      beat_t;
    typedef logic [$clog2(BEATS)-1:0]  beat_cnt_t;

    // Line read request, read is a single-cycle strobe
    typedef struct packed {
        logic                 read;
        logic [ADDR_BITS-1:0] addr;
    } mem_req_t;

    // One returned beat, valid is a single-cycle strobe
    typedef struct packed {
        logic  valid;
        beat_t data;
    } mem_rsp_t;

endpackage

//--- hw/refill_counter.sv
`timescale 1ns/1ps

module refill_counter
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // Refill starts with the memory request
    input  logic      start,
    // One pulse per returned beat
    input  logic      beat,

    output beat_cnt_t idx,
    output logic      last
);

    // Beat index of the next beat to arrive
    always_ff @(posedge clk) begin
        if (rst || start) begin
            idx <= '0;
        end else if (beat) begin
            idx <= idx + 1'b1;
        end
    end

    // High while waiting for, and during, the final beat of the line
    assign last = (idx == beat_cnt_t'(BEATS - 1));

endmodule

//--- tests/fetch_chk.sv
`timescale 1ns/1ps

module fetch_chk
    import fetch_pkg::*, mem_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input logic     flush,
    input logic     nxt_valid,
    input logic     nxt_ready,
    input addr_t    pc,
    input mem_req_t mem_req,
    input mem_rsp_t mem_rsp
);

    // Number of failed assertions
    int violations = 0;

    // Beats memory still owes for the current line
    int beats_left;

    always_ff @(posedge clk) begin
        if (rst) begin
            beats_left <= 0;
        end else if (mem_req.read) begin
            beats_left <= BEATS;
        end else if (mem_rsp.valid) begin
            beats_left <= beats_left - 1;
        end
    end

    stall_hold: assert property (@(posedge clk) disable iff (rst)
        nxt_valid && !nxt_ready |=> flush || (nxt_valid && $stable(pc)))
    else begin
        $error("nxt_valid or pc changed under back-pressure");
        violations++;
    end

    single_refill: assert property (@(posedge clk) disable iff (rst)
        mem_req.read |-> beats_left == 0)
    else begin
        $error("Line request issued while a refill is outstanding");
        violations++;
    end

    quiet_after_reset: assert property (@(posedge clk)
        rst |=> !nxt_valid && !mem_req.read)
    else begin
        $error("Output valid or line request right after reset");
        violations++;
    end

endmodule

//--- tests/tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch
    import fetch_pkg::*, mem_pkg::*;
;

    localparam int CLK_PERIOD = 8;
    localparam int N_FETCH    = 400;
    localparam int MEM_WORDS  = 1024;

    logic       clk;
    logic       rst;
    logic       flush;
    logic       prv_valid;
    logic       prv_ready;
    logic       nxt_valid;
    logic       nxt_ready;
    addr_t      pc_next;
    addr_t      pc;
    fetch_blk_t insts;
    mem_req_t   mem_req;
    mem_rsp_t   mem_rsp;

    integer     seed = 3;
    inst_t      mem_words [MEM_WORDS];

    // Reference model state
    addr_t      pending_q [$];
    addr_t      lookup_q [$];
    logic       line_valid [SETS];
    tag_t       line_tag [SETS];
    int         transfers = 0;
    int         requests = 0;
    logic       seen_accept = 1'b0;
    logic       accepted = 1'b0;
    logic       stalled = 1'b0;
    addr_t      held_pc;
    fetch_blk_t held_blk;

    fetch_top dut (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .prv_valid (prv_valid),
        .prv_ready (prv_ready),
        .nxt_valid (nxt_valid),
        .nxt_ready (nxt_ready),
        .pc_next   (pc_next),
        .pc        (pc),
        .insts     (insts),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

    bind if1_stage fetch_chk chk_i (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .nxt_valid (nxt_valid),
        .nxt_ready (nxt_ready),
        .pc        (pc),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic addr_t line_of(input addr_t a);
        return a & ~addr_t'(LINE_WORDS * 4 - 1);
    endfunction

    // Word at the lower address sits in element 0
    function automatic fetch_blk_t model_blk(input addr_t a);
        fetch_blk_t b;
        for (int i = 0; i < IF_WIDTH; i++) begin
            b[i] = mem_words[a[11:2] + i];
        end
        return b;
    endfunction

    function automatic beat_t model_beat(input addr_t line, input int b);
        return {mem_words[line[11:2] + 2 * b + 1], mem_words[line[11:2] + 2 * b]};
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_blk(input fetch_blk_t got, input fetch_blk_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t ns: %s, got %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_pc(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t ns: %s, got %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_req(input mem_req_t got, input mem_req_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t ns: %s, got %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_ready(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t ns: %s, got %b, expected %b",
                                $time, what, got, exp));
        end
    endtask

    // Request must serve a fetch in accept order and name an absent line
    task automatic check_request();
        mem_req_t exp;
        index_t   set;
        int       found;
        found = -1;
        foreach (lookup_q[i]) begin
            if (found < 0 && line_of(lookup_q[i]) == line_of(mem_req.addr)) begin
                found = i;
            end
        end
        if (lookup_q.size() == 0) begin
            abort_run("Line request while no fetch was waiting for the cache");
        end else begin
            exp.read = 1'b1;
            exp.addr = line_of(lookup_q[found < 0 ? 0 : found]);
            check_req(mem_req, exp, "line request");
            repeat (found + 1) void'(lookup_q.pop_front());
            set = exp.addr[OFFSET_BITS +: INDEX_BITS];
            if (line_valid[set] &&
                line_tag[set] == exp.addr[OFFSET_BITS + INDEX_BITS +: TAG_BITS]) begin
                abort_run("Line request for a line that is already in the cache");
            end
            line_valid[set] = 1'b1;
            line_tag[set]   = exp.addr[OFFSET_BITS + INDEX_BITS +: TAG_BITS];
            requests++;
        end
    endtask

    // Evaluated between edges, so it sees what the next edge will act on
    task automatic monitor_cycle();
        logic xfer;
        xfer     = nxt_valid && nxt_ready;
        accepted = prv_valid && prv_ready;
        // Stage takes a new fetch when empty, draining or flushed
        check_ready(prv_ready, pending_q.size() == 0 || xfer || flush, "prv_ready");
        if (dut.if1_i.chk_i.violations != 0) begin
            abort_run("A bound assertion on the fetch stage failed");
        end
        if (!seen_accept && (nxt_valid || mem_req.read)) begin
            abort_run("Output valid or line request before the first accepted fetch");
        end
        if (stalled && !flush) begin
            if (!nxt_valid) begin
                abort_run("nxt_valid dropped under back-pressure");
            end
            check_pc(pc, held_pc, "pc under back-pressure");
            check_blk(insts, held_blk, "insts under back-pressure");
        end
        stalled  = nxt_valid && !nxt_ready;
        held_pc  = pc;
        held_blk = insts;
        if (mem_req.read) begin
            check_request();
        end
        if (xfer && pending_q.size() == 0) begin
            abort_run("Transfer seen with no outstanding fetch");
        end else if (xfer && requests == 0) begin
            abort_run("First transfer came without any line request");
        end else if (xfer) begin
            check_pc(pc, pending_q[0], "transfer pc");
            check_blk(insts, model_blk(pending_q[0]), "transfer insts");
            void'(pending_q.pop_front());
            transfers++;
        end
        // Fetches accepted before a flush never come out
        if (flush) begin
            pending_q.delete();
        end
        if (accepted) begin
            pending_q.push_back(pc_next);
            lookup_q.push_back(pc_next);
            seen_accept = 1'b1;
        end
    endtask

    // About 70% sequential, the rest jumps anywhere in 4 KB
    task automatic drive_inputs();
        if (accepted || !prv_valid) begin
            if (rand_below(10) < 7) begin
                pc_next <= (pc_next + BLK_BYTES) & 32'h0000_0ff8;
            end else begin
                pc_next <= addr_t'(rand_below(512)) * BLK_BYTES;
            end
        end
        prv_valid <= (rand_below(4) != 0);
        nxt_ready <= (rand_below(4) != 0);
        flush     <= (rand_below(40) == 0);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(negedge clk) begin
        if (!rst) begin
            monitor_cycle();
        end
    end

    // Burst memory, BEATS beats per request with gaps of 0 to 3 cycles
    initial begin : memory_model
        addr_t line;
        int    gaps [BEATS];
        mem_rsp <= '0;
        forever begin
            @(negedge clk);
            if (mem_req.read) begin
                line = mem_req.addr;
                foreach (gaps[b]) begin
                    gaps[b] = rand_below(4);
                end
                for (int b = 0; b < BEATS; b++) begin
                    repeat (gaps[b]) begin
                        @(posedge clk);
                        mem_rsp.valid <= 1'b0;
                    end
                    @(posedge clk);
                    mem_rsp.valid <= 1'b1;
                    mem_rsp.data  <= model_beat(line, b);
                end
                @(posedge clk);
                mem_rsp.valid <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(N_FETCH * 40 * CLK_PERIOD);
        abort_run("Watchdog expired before all fetches completed");
    end

    initial begin
        rst       <= 1'b1;
        flush     <= 1'b0;
        prv_valid <= 1'b0;
        nxt_ready <= 1'b0;
        pc_next   <= '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_words[i] = $random(seed);
        end
        for (int s = 0; s < SETS; s++) begin
            line_valid[s] = 1'b0;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        while (transfers < N_FETCH) begin
            @(posedge clk);
            drive_inputs();
        end
        if (dut.if1_i.chk_i.violations == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            abort_run("A bound assertion on the fetch stage failed");
        end
    end

endmodule
